/* all.f */
hw/tile_pkg.sv
hw/pkt_mem.sv
hw/csum_engine.sv
hw/slot_tracker.sv
hw/tile_ctrl.sv
hw/pkt_tile.sv
sim/tb_pkt_tile.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --top-module tb_pkt_tile -f all.f -Mdir obj_dir -o tb_pkt_tile

run: compile
	@out="$$(./obj_dir/tb_pkt_tile)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir

/* sim/tb_pkt_tile.sv */
`timescale 1ns/1ps

module tb_pkt_tile import tile_pkg::*; ();

  localparam int SLOT_COUNT = 8;
  localparam int SLOT_WORDS = 16;
  localparam int DEPTH      = SLOT_COUNT * SLOT_WORDS;
  localparam int ADDR_W     = $clog2(DEPTH);
  localparam int TIMEOUT    = 200;

  logic                  clk;
  logic                  rst_n;
  logic                  dma_wr_en;
  logic [ADDR_W-1:0]     dma_wr_addr;
  logic [WORD_W-1:0]     dma_wr_data;
  logic                  dma_rd_en;
  logic [ADDR_W-1:0]     dma_rd_addr;
  logic                  dma_rd_valid;
  logic [WORD_W-1:0]     dma_rd_data;
  desc_t                 in_desc;
  logic                  in_desc_valid;
  logic                  in_desc_taken;
  cmpl_t                 out_cmpl;
  logic                  out_cmpl_valid;
  logic                  out_cmpl_ready;
  logic                  slot_free;
  logic [SLOT_ID_W-1:0]  slot_free_id;
  logic [SLOT_COUNT-1:0] busy_slots;
  status_t               core_status;

  // Copy of what the host wrote into packet memory
  logic [WORD_W-1:0] mem_model [DEPTH];
  status_t           exp_status;
  integer            seed;
  int                err_count;
  int                check_count;

  pkt_tile #(
    .SLOT_COUNT(SLOT_COUNT),
    .SLOT_WORDS(SLOT_WORDS)
  ) u_dut (.*);

  initial clk = 1'b0;
  always #2 clk = ~clk;

  //////////////////////////////////////////////////
  // Compare tasks

  task automatic check_bit(input string msg, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Fail at %0t: %s, got %b expected %b", $time, msg, got, exp);
    end
  endtask

  task automatic check_map(input string msg, input logic [SLOT_COUNT-1:0] got,
                           input logic [SLOT_COUNT-1:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Fail at %0t: %s, got %b expected %b", $time, msg, got, exp);
    end
  endtask

  task automatic check_word(input string msg, input logic [WORD_W-1:0] got,
                            input logic [WORD_W-1:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Fail at %0t: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_cmpl(input string msg, input cmpl_t got, input cmpl_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Fail at %0t: %s, got slot %0d len %0d tag %h csum %h, expected %0d %0d %h %h",
               $time, msg, got.slot, got.len, got.tag, got.csum,
               exp.slot, exp.len, exp.tag, exp.csum);
    end
  endtask

  task automatic check_status(input string msg, input status_t got, input status_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Fail at %0t: %s, got done %0d dupl %0d inv %0d, expected %0d %0d %0d",
               $time, msg, got.done_count, got.dupl_count, got.inv_count,
               exp.done_count, exp.dupl_count, exp.inv_count);
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model

  // Wide sum of all 16-bit halves with the carries folded back in, then inverted
  function automatic logic [15:0] ref_csum(input int slot, input int len);
    logic [31:0] acc;
    logic [31:0] w;
    acc = 32'd0;
    for (int i = 0; i < len; i++) begin
      w   = mem_model[slot * SLOT_WORDS + i];
      acc = acc + {16'd0, w[31:16]} + {16'd0, w[15:0]};
    end
    while (acc > 32'h0000_FFFF) begin
      acc = {16'd0, acc[15:0]} + {16'd0, acc[31:16]};
    end
    return ~acc[15:0];
  endfunction

  function automatic desc_t make_desc(input int slot, input int len, input int tag);
    desc_t d;
    d.slot = SLOT_ID_W'(slot);
    d.len  = LEN_W'(len);
    d.tag  = 8'(tag);
    return d;
  endfunction

  function automatic cmpl_t expect_cmpl(input int slot, input int len, input int tag);
    cmpl_t c;
    c.slot = SLOT_ID_W'(slot);
    c.len  = LEN_W'(len);
    c.tag  = 8'(tag);
    c.csum = ref_csum(slot, len);
    return c;
  endfunction

  //////////////////////////////////////////////////
  // Bus tasks

  task automatic dma_write(input int addr, input logic [WORD_W-1:0] data);
    @(negedge clk);
    dma_wr_en   = 1'b1;
    dma_wr_addr = ADDR_W'(addr);
    dma_wr_data = data;
    @(negedge clk);
    dma_wr_en = 1'b0;
  endtask

  // Response must show up on the next edge and last one cycle
  task automatic dma_read_compare(input int addr);
    @(negedge clk);
    check_bit("read valid idle before request", dma_rd_valid, 1'b0);
    dma_rd_en   = 1'b1;
    dma_rd_addr = ADDR_W'(addr);
    @(negedge clk);
    dma_rd_en = 1'b0;
    check_bit("read valid one cycle after request", dma_rd_valid, 1'b1);
    check_word($sformatf("read data at %0d", addr), dma_rd_data, mem_model[addr]);
    @(negedge clk);
    check_bit("read valid drops after one cycle", dma_rd_valid, 1'b0);
  endtask

  task automatic wait_taken();
    int n;
    n = 0;
    #1;
    while (!in_desc_taken && n < TIMEOUT) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (!in_desc_taken) begin
      err_count++;
      $display("Timed out waiting for the tile to take a descriptor");
    end
    @(negedge clk);
    in_desc_valid = 1'b0;
  endtask

  task automatic offer_desc(input desc_t d);
    @(negedge clk);
    in_desc       = d;
    in_desc_valid = 1'b1;
    wait_taken();
  endtask

  task automatic wait_cmpl(output cmpl_t got);
    int n;
    n = 0;
    @(negedge clk);
    while (!out_cmpl_valid && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!out_cmpl_valid) begin
      err_count++;
      $display("Timed out waiting for a completion descriptor");
    end
    got = out_cmpl;
  endtask

  // Called on a falling edge with the completion pending
  task automatic accept_cmpl();
    out_cmpl_ready = 1'b1;
    @(negedge clk);
    out_cmpl_ready = 1'b0;
  endtask

  task automatic run_desc(input int slot, input int len, input int tag);
    cmpl_t got;
    offer_desc(make_desc(slot, len, tag));
    wait_cmpl(got);
    check_cmpl($sformatf("completion for slot %0d", slot), got, expect_cmpl(slot, len, tag));
    accept_cmpl();
    exp_status.done_count = exp_status.done_count + 16'd1;
  endtask

  task automatic expect_no_cmpl(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      check_bit("no completion for a dropped descriptor", out_cmpl_valid, 1'b0);
    end
  endtask

  task automatic report_test(input string name, input int base_err);
    $display("%s: finished with %0d errors", name, err_count - base_err);
  endtask

  //////////////////////////////////////////////////
  // Tests

  task automatic reset_values();
    int base_err;
    base_err = err_count;
    @(negedge clk);
    check_bit("completion valid after reset", out_cmpl_valid, 1'b0);
    check_bit("descriptor taken after reset", in_desc_taken, 1'b0);
    check_map("busy slots after reset", busy_slots, '0);
    check_status("status after reset", core_status, exp_status);
    report_test("reset_values", base_err);
  endtask

  task automatic dma_readback();
    int          base_err;
    logic [31:0] data;
    base_err = err_count;
    for (int a = 0; a < DEPTH; a++) begin
      data         = $random(seed);
      mem_model[a] = data;
      dma_write(a, data);
    end
    for (int s = 0; s < SLOT_COUNT; s++) begin
      dma_read_compare(s * SLOT_WORDS);
      dma_read_compare(s * SLOT_WORDS + s + 3);
      dma_read_compare(s * SLOT_WORDS + SLOT_WORDS - 1);
    end
    report_test("dma_readback", base_err);
  endtask

  task automatic checksum_completions();
    int base_err;
    base_err = err_count;
    run_desc(0, SLOT_WORDS, 8'hA0);
    run_desc(1, 5, 8'hA1);
    run_desc(2, 1, 8'hA2);
    run_desc(3, 11, 8'hA3);
    check_status("done count after four packets", core_status, exp_status);
    check_map("slots claimed by completions", busy_slots, 8'h0F);
    report_test("checksum_completions", base_err);
  endtask

  task automatic completion_backpressure();
    int    base_err;
    cmpl_t held;
    cmpl_t got;
    base_err = err_count;
    offer_desc(make_desc(4, 6, 8'h44));
    wait_cmpl(held);
    check_cmpl("stalled completion", held, expect_cmpl(4, 6, 8'h44));
    // Second descriptor waits behind the stalled completion
    in_desc       = make_desc(5, 3, 8'h55);
    in_desc_valid = 1'b1;
    for (int i = 0; i < 8; i++) begin
      #1;
      check_bit("completion held under back-pressure", out_cmpl_valid, 1'b1);
      check_cmpl("completion stable under back-pressure", out_cmpl, expect_cmpl(4, 6, 8'h44));
      check_bit("second descriptor not taken", in_desc_taken, 1'b0);
      @(negedge clk);
    end
    out_cmpl_ready = 1'b1;
    #1;
    check_bit("second descriptor not taken before transfer", in_desc_taken, 1'b0);
    @(negedge clk);
    out_cmpl_ready        = 1'b0;
    exp_status.done_count = exp_status.done_count + 16'd1;
    wait_taken();
    wait_cmpl(got);
    check_cmpl("completion after the stall", got, expect_cmpl(5, 3, 8'h55));
    accept_cmpl();
    exp_status.done_count = exp_status.done_count + 16'd1;
    check_status("done count after back-pressure", core_status, exp_status);
    report_test("completion_backpressure", base_err);
  endtask

  task automatic busy_slot_drop();
    int base_err;
    base_err = err_count;
    // Slot 4 still owned from the previous test
    offer_desc(make_desc(4, 3, 8'h60));
    expect_no_cmpl(40);
    exp_status.dupl_count = exp_status.dupl_count + 8'd1;
    check_status("duplicate slot counted", core_status, exp_status);
    @(negedge clk);
    slot_free    = 1'b1;
    slot_free_id = SLOT_ID_W'(4);
    @(negedge clk);
    slot_free = 1'b0;
    check_bit("slot 4 released", busy_slots[4], 1'b0);
    run_desc(4, 7, 8'h61);
    check_bit("slot 4 owned again", busy_slots[4], 1'b1);
    check_status("status after reuse", core_status, exp_status);
    report_test("busy_slot_drop", base_err);
  endtask

  task automatic invalid_length_drop();
    int base_err;
    base_err = err_count;
    offer_desc(make_desc(6, 0, 8'h70));
    expect_no_cmpl(40);
    exp_status.inv_count = exp_status.inv_count + 8'd1;
    // Slot 5 is still owned, a bad length outranks the busy slot
    offer_desc(make_desc(5, SLOT_WORDS + 1, 8'h71));
    expect_no_cmpl(40);
    exp_status.inv_count = exp_status.inv_count + 8'd1;
    check_status("invalid lengths counted", core_status, exp_status);
    check_map("no slot claimed by a bad length", busy_slots, 8'h3F);
    report_test("invalid_length_drop", base_err);
  endtask

  //////////////////////////////////////////////////
  // Sequence

  initial begin
    seed           = 11979;
    err_count      = 0;
    check_count    = 0;
    exp_status     = '0;
    rst_n          = 1'b0;
    dma_wr_en      = 1'b0;
    dma_wr_addr    = '0;
    dma_wr_data    = '0;
    dma_rd_en      = 1'b0;
    dma_rd_addr    = '0;
    in_desc        = '0;
    in_desc_valid  = 1'b0;
    out_cmpl_ready = 1'b0;
    slot_free      = 1'b0;
    slot_free_id   = '0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    reset_values();
    dma_readback();
    checksum_completions();
    completion_backpressure();
    busy_slot_drop();
    invalid_length_drop();

    $display("Checks run: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* hw/pkt_tile.sv */
`timescale 1ns/1ps

module pkt_tile import tile_pkg::*; #(
  parameter int SLOT_COUNT = 8,
  parameter int SLOT_WORDS = 16
) (
  input  logic                                     clk,
  input  logic                                     rst_n,

  // DMA port
  input  logic                                     dma_wr_en,
  input  logic [$clog2(SLOT_COUNT*SLOT_WORDS)-1:0] dma_wr_addr,
  input  logic [WORD_W-1:0]                        dma_wr_data,
  input  logic                                     dma_rd_en,
  input  logic [$clog2(SLOT_COUNT*SLOT_WORDS)-1:0] dma_rd_addr,
  output logic                                     dma_rd_valid,
  output logic [WORD_W-1:0]                        dma_rd_data,

  // Descriptors
  input  desc_t                                    in_desc,
  input  logic                                     in_desc_valid,
  output logic                                     in_desc_taken,
  output cmpl_t                                    out_cmpl,
  output logic                                     out_cmpl_valid,
  input  logic                                     out_cmpl_ready,

  // Slot release and status
  input  logic                                     slot_free,
  input  logic [SLOT_ID_W-1:0]                     slot_free_id,
  output logic [SLOT_COUNT-1:0]                    busy_slots,
  output status_t                                  core_status
);

  localparam int ADDR_W = $clog2(SLOT_COUNT * SLOT_WORDS);

  logic                 claim_req;
  logic [SLOT_ID_W-1:0] claim_slot;
  logic                 slot_busy;

  logic                 eng_start;
  logic [SLOT_ID_W-1:0] eng_slot;
  logic [LEN_W-1:0]     eng_len;
  logic                 eng_done;
  logic [15:0]          eng_csum;

  logic                 mem_rd_en;
  logic [ADDR_W-1:0]    mem_rd_addr;
  logic [WORD_W-1:0]    mem_rd_data;

  //////////////////////////////////////////////////
  // Packet memory

  pkt_mem #(
    .SLOT_COUNT(SLOT_COUNT),
    .SLOT_WORDS(SLOT_WORDS)
  ) u_pkt_mem (
    .clk         (clk),
    .rst_n       (rst_n),
    .dma_wr_en   (dma_wr_en),
    .dma_wr_addr (dma_wr_addr),
    .dma_wr_data (dma_wr_data),
    .dma_rd_en   (dma_rd_en),
    .dma_rd_addr (dma_rd_addr),
    .dma_rd_valid(dma_rd_valid),
    .dma_rd_data (dma_rd_data),
    .eng_rd_en   (mem_rd_en),
    .eng_rd_addr (mem_rd_addr),
    .eng_rd_data (mem_rd_data)
  );

  //////////////////////////////////////////////////
  // Slot ownership

  slot_tracker #(
    .SLOT_COUNT(SLOT_COUNT)
  ) u_slot_tracker (
    .clk         (clk),
    .rst_n       (rst_n),
    .claim_req   (claim_req),
    .claim_slot  (claim_slot),
    .slot_busy   (slot_busy),
    .slot_free   (slot_free),
    .slot_free_id(slot_free_id),
    .busy_map    (busy_slots)
  );

  //////////////////////////////////////////////////
  // Checksum engine

  csum_engine #(
    .SLOT_COUNT(SLOT_COUNT),
    .SLOT_WORDS(SLOT_WORDS)
  ) u_csum_engine (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (eng_start),
    .slot   (eng_slot),
    .len    (eng_len),
    .rd_en  (mem_rd_en),
    .rd_addr(mem_rd_addr),
    .rd_data(mem_rd_data),
    .done   (eng_done),
    .csum   (eng_csum)
  );

  //////////////////////////////////////////////////
  // Descriptor controller

  tile_ctrl #(
    .SLOT_COUNT(SLOT_COUNT),
    .SLOT_WORDS(SLOT_WORDS)
  ) u_tile_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_desc       (in_desc),
    .in_desc_valid (in_desc_valid),
    .in_desc_taken (in_desc_taken),
    .out_cmpl      (out_cmpl),
    .out_cmpl_valid(out_cmpl_valid),
    .out_cmpl_ready(out_cmpl_ready),
    .claim_req     (claim_req),
    .claim_slot    (claim_slot),
    .slot_busy     (slot_busy),
    .eng_start     (eng_start),
    .eng_slot      (eng_slot),
    .eng_len       (eng_len),
    .eng_done      (eng_done),
    .eng_csum      (eng_csum),
    .core_status   (core_status)
  );

endmodule

/* hw/tile_ctrl.sv */
`timescale 1ns/1ps

module tile_ctrl import tile_pkg::*; #(
  parameter int SLOT_COUNT = 8,
  parameter int SLOT_WORDS = 16
) (
  input  logic                 clk,
  input  logic                 rst_n,

  // Descriptor in
  input  desc_t                in_desc,
  input  logic                 in_desc_valid,
  output logic                 in_desc_taken,

  // Completion out
  output cmpl_t                out_cmpl,
  output logic                 out_cmpl_valid,
  input  logic                 out_cmpl_ready,

  // Slot tracker
  output logic                 claim_req,
  output logic [SLOT_ID_W-1:0] claim_slot,
  input  logic                 slot_busy,

  // Checksum engine
  output logic                 eng_start,
  output logic [SLOT_ID_W-1:0] eng_slot,
  output logic [LEN_W-1:0]     eng_len,
  input  logic                 eng_done,
  input  logic [15:0]          eng_csum,

  output status_t              core_status
);

  ctrl_state_e state_q;
  desc_t       desc_q;
  logic [15:0] csum_q;
  status_t     status_q;
  err_e        err;

  //////////////////////////////////////////////////
  // Descriptor classification

  always_comb begin
    err = ERR_NONE;
    if (desc_q.len == '0 || 32'(desc_q.len) > SLOT_WORDS) begin
      err = ERR_INV_LEN;
    end else if (slot_busy) begin
      err = ERR_DUPL_SLOT;
    end
  end

  //////////////////////////////////////////////////
  // Handshakes and engine launch

  assign in_desc_taken  = (state_q == IDLE) && in_desc_valid;
  assign out_cmpl_valid = (state_q == SEND);

  // Claim and engine start share the CHECK edge
  assign claim_req  = (state_q == CHECK) && (err == ERR_NONE);
  assign claim_slot = desc_q.slot;
  assign eng_start  = claim_req;
  assign eng_slot   = desc_q.slot;
  assign eng_len    = desc_q.len;

  always_comb begin
    out_cmpl.slot = desc_q.slot;
    out_cmpl.len  = desc_q.len;
    out_cmpl.tag  = desc_q.tag;
    out_cmpl.csum = csum_q;
  end

  assign core_status = status_q;

  //////////////////////////////////////////////////
  // State machine and counters

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q  <= IDLE;
      status_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (in_desc_valid) begin
            state_q <= CHECK;
          end
        end
        CHECK: begin
          case (err)
            ERR_INV_LEN: begin
              state_q <= IDLE;
              if (status_q.inv_count != '1) begin
                status_q.inv_count <= status_q.inv_count + 8'd1;
              end
            end
            ERR_DUPL_SLOT: begin
              state_q <= IDLE;
              if (status_q.dupl_count != '1) begin
                status_q.dupl_count <= status_q.dupl_count + 8'd1;
              end
            end
            default: state_q <= RUN;
          endcase
        end
        RUN: begin
          if (eng_done) begin
            state_q <= SEND;
          end
        end
        SEND: begin
          // Held here under back-pressure
          if (out_cmpl_ready) begin
            state_q             <= IDLE;
            status_q.done_count <= status_q.done_count + 16'd1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (in_desc_taken) begin
      desc_q <= in_desc;
    end
    if (state_q == RUN && eng_done) begin
      csum_q <= eng_csum;
    end
  end

endmodule

/* hw/slot_tracker.sv */
`timescale 1ns/1ps

module slot_tracker import tile_pkg::*; #(
  parameter int SLOT_COUNT = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,

  // Claim from the controller
  input  logic                  claim_req,
  input  logic [SLOT_ID_W-1:0]  claim_slot,
  output logic                  slot_busy,

  // Host release
  input  logic                  slot_free,
  input  logic [SLOT_ID_W-1:0]  slot_free_id,

  output logic [SLOT_COUNT-1:0] busy_map
);

  // Answer is combinational so CHECK can decide in one cycle
  assign slot_busy = busy_map[claim_slot];

  //////////////////////////////////////////////////
  // Ownership bitmap

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_map <= '0;
    end else begin
      if (claim_req && !slot_busy) begin
        busy_map[claim_slot] <= 1'b1;
      end
      // Release comes last, wins on a same-slot collision
      if (slot_free) begin
        busy_map[slot_free_id] <= 1'b0;
      end
    end
  end

endmodule

/* hw/csum_engine.sv */
`timescale 1ns/1ps

module csum_engine import tile_pkg::*; #(
  parameter int SLOT_COUNT = 8,
  parameter int SLOT_WORDS = 16
) (
  input  logic                                     clk,
  input  logic                                     rst_n,

  input  logic                                     start,
  input  logic [SLOT_ID_W-1:0]                     slot,
  input  logic [LEN_W-1:0]                         len,

  output logic                                     rd_en,
  output logic [$clog2(SLOT_COUNT*SLOT_WORDS)-1:0] rd_addr,
  input  logic [WORD_W-1:0]                        rd_data,

  output logic                                     done,
  output logic [15:0]                              csum
);

  localparam int ADDR_W = $clog2(SLOT_COUNT * SLOT_WORDS);

  // 16-bit ones-complement add with end-around carry
  function automatic logic [15:0] oc_add(input logic [15:0] a, input logic [15:0] b);
    logic [16:0] s;
    s = {1'b0, a} + {1'b0, b};
    return s[15:0] + {15'd0, s[16]};
  endfunction

  logic              rd_active;
  logic [LEN_W-1:0]  rd_left;
  logic [ADDR_W-1:0] rd_addr_q;
  logic              data_vld;
  logic [LEN_W-1:0]  data_left;
  logic [15:0]       sum;
  logic [15:0]       sum_next;

  assign rd_en   = rd_active;
  assign rd_addr = rd_addr_q;

  // Both halves of the returned word folded into the running sum
  assign sum_next = oc_add(oc_add(sum, rd_data[31:16]), rd_data[15:0]);

  //////////////////////////////////////////////////
  // Control

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_active <= 1'b0;
      data_vld  <= 1'b0;
      done      <= 1'b0;
    end else begin
      data_vld <= rd_en;
      done     <= 1'b0;
      if (start) begin
        rd_active <= (len != '0);
      end else if (rd_active && rd_left == LEN_W'(1)) begin
        rd_active <= 1'b0;
      end
      if (data_vld && data_left == LEN_W'(1)) begin
        done <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Address and accumulator

  always_ff @(posedge clk) begin
    if (start) begin
      rd_addr_q <= ADDR_W'(slot * SLOT_WORDS);
      rd_left   <= len;
      data_left <= len;
      sum       <= '0;
    end else begin
      if (rd_active) begin
        rd_addr_q <= rd_addr_q + ADDR_W'(1);
        rd_left   <= rd_left - LEN_W'(1);
      end
      if (data_vld) begin
        data_left <= data_left - LEN_W'(1);
        sum       <= sum_next;
        // Result is the complement of the sum once the last word is in
        if (data_left == LEN_W'(1)) begin
          csum <= ~sum_next;
        end
      end
    end
  end

endmodule

/* hw/pkt_mem.sv */
`timescale 1ns/1ps

module pkt_mem import tile_pkg::*; #(
  parameter int SLOT_COUNT = 8,
  parameter int SLOT_WORDS = 16
) (
  input  logic                                     clk,
  input  logic                                     rst_n,

  // DMA port, plain strobes
  input  logic                                     dma_wr_en,
  input  logic [$clog2(SLOT_COUNT*SLOT_WORDS)-1:0] dma_wr_addr,
  input  logic [WORD_W-1:0]                        dma_wr_data,

  input  logic                                     dma_rd_en,
  input  logic [$clog2(SLOT_COUNT*SLOT_WORDS)-1:0] dma_rd_addr,
  output logic                                     dma_rd_valid,
  output logic [WORD_W-1:0]                        dma_rd_data,

  // Checksum engine read port
  input  logic                                     eng_rd_en,
  input  logic [$clog2(SLOT_COUNT*SLOT_WORDS)-1:0] eng_rd_addr,
  output logic [WORD_W-1:0]                        eng_rd_data
);

  // Slots laid out back to back, slot index in the upper address bits
  localparam int DEPTH = SLOT_COUNT * SLOT_WORDS;

  logic [WORD_W-1:0] mem [DEPTH];

  //////////////////////////////////////////////////
  // Write port

  always_ff @(posedge clk) begin
    if (dma_wr_en) begin
      mem[dma_wr_addr] <= dma_wr_data;
    end
  end

  //////////////////////////////////////////////////
  // DMA read port

  always_ff @(posedge clk) begin
    if (dma_rd_en) begin
      dma_rd_data <= mem[dma_rd_addr];
    end
  end

  // Response strobe, one cycle after the request
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dma_rd_valid <= 1'b0;
    end else begin
      dma_rd_valid <= dma_rd_en;
    end
  end

  //////////////////////////////////////////////////
  // Engine read port

  // Same latency as the DMA side, engine tracks its own valid
  always_ff @(posedge clk) begin
    if (eng_rd_en) begin
      eng_rd_data <= mem[eng_rd_addr];
    end
  end

endmodule

/* hw/tile_pkg.sv */
package tile_pkg;

  //////////////////////////////////////////////////
  // Widths

  localparam int WORD_W    = 32;
  localparam int SLOT_ID_W = 3;
  localparam int LEN_W     = 5;

  //////////////////////////////////////////////////
  // Descriptors

  // Host request, slot index in the top bits
  typedef struct packed {
    logic [SLOT_ID_W-1:0] slot;
    logic [LEN_W-1:0]     len;
    logic [7:0]           tag;
  } desc_t;

  // Completion returned to the host
  typedef struct packed {
    logic [SLOT_ID_W-1:0] slot;
    logic [LEN_W-1:0]     len;
    logic [7:0]           tag;
    logic [15:0]          csum;
  } cmpl_t;

  //////////////////////////////////////////////////
  // Status and control encodings

  typedef struct packed {
    logic [15:0] done_count;
    logic [7:0]  dupl_count;
    logic [7:0]  inv_count;
  } status_t;

  // Reason a descriptor was dropped
  typedef enum logic [1:0] {
    ERR_NONE,
    ERR_DUPL_SLOT,
    ERR_INV_LEN
  } err_e;

  typedef enum logic [1:0] {
    IDLE,
    CHECK,
    RUN,
    SEND
  } ctrl_state_e;

endpackage
